//--- verilog/regex_isa_pkg.sv
// regex instruction set: opcode encoding and instruction field layout
package regex_isa_pkg;

    localparam int OPCODE_WIDTH = 3;

    // data field holds a character in its low bits or a target pc
    localparam int INSTR_DATA_WIDTH = 13;

    // one instruction fills one program memory word, opcode on top
    localparam int INSTR_WIDTH = OPCODE_WIDTH + INSTR_DATA_WIDTH;

    typedef enum logic [OPCODE_WIDTH-1:0] {
        ACCEPT         = 3'd0,
        SPLIT          = 3'd1,
        MATCH          = 3'd2,
        NOT_MATCH      = 3'd3,
        MATCH_ANY      = 3'd4,
        JMP            = 3'd5,
        END_NO_ACCEPT  = 3'd6,
        ACCEPT_PARTIAL = 3'd7
    } regex_opcode_e;

endpackage

//--- verilog/regex_engine_pkg.sv
// regex engine dimensions used as default parameter values
package regex_engine_pkg;

    localparam int DEF_PC_WIDTH = 9;

    // four character slots in the window
    localparam int DEF_CC_ID_BITS = 2;

    localparam int DEF_CHAR_WIDTH = 8;

    localparam int DEF_MEM_ADDR_WIDTH = 11;

endpackage

//--- verilog/regex_fetch.sv
// fetch stage issuing program memory requests and holding the returned instruction
`timescale 1ns/1ps

module regex_fetch #(
    parameter int PC_WIDTH       = 9,
    parameter int CC_ID_BITS     = 2,
    parameter int MEM_ADDR_WIDTH = 11
)(
    input  logic                                   clk,
    input  logic                                   rst,

    input  logic                                   input_pc_valid,
    input  logic [PC_WIDTH-1:0]                    input_pc,
    input  logic [CC_ID_BITS-1:0]                  input_cc_id,
    output logic                                   input_pc_ready,

    output logic                                   memory_valid,
    output logic [MEM_ADDR_WIDTH-1:0]              memory_addr,
    input  logic                                   memory_ready,
    input  logic [regex_isa_pkg::INSTR_WIDTH-1:0]  memory_data,

    input  logic                                   fetch_advance,
    output logic                                   fetch_valid,
    output logic [PC_WIDTH-1:0]                    fetch_pc,
    output logic [CC_ID_BITS-1:0]                  fetch_cc_id,
    output logic [regex_isa_pkg::INSTR_WIDTH-1:0]  fetch_instr
);

    logic                                  has_to_save;
    logic [regex_isa_pkg::INSTR_WIDTH-1:0] instr_q;
    logic                                  token_accept;

    // a request may go out only if the register is free or emptying this cycle
    assign memory_valid   = input_pc_valid && (!fetch_valid || fetch_advance);
    assign token_accept   = memory_valid && memory_ready;
    assign input_pc_ready = token_accept;
    assign memory_addr    = {{(MEM_ADDR_WIDTH-PC_WIDTH){1'b0}}, input_pc};

    // memory data is only valid in the cycle right after the request
    assign fetch_instr = has_to_save ? memory_data : instr_q;

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            fetch_valid <= 1'b0;
            has_to_save <= 1'b0;
        end
        else
        begin
            has_to_save <= token_accept;
            if (token_accept)
            begin
                fetch_valid <= 1'b1;
            end
            else if (fetch_advance)
            begin
                fetch_valid <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk)
    begin
        if (token_accept)
        begin
            fetch_pc    <= input_pc;
            fetch_cc_id <= input_cc_id;
        end
        // keep the word for a stalled fetch stage
        if (has_to_save)
        begin
            instr_q <= memory_data;
        end
    end

endmodule

//--- verilog/regex_pipe_ctrl.sv
// pipeline control deciding stage advances and reporting occupancy
`timescale 1ns/1ps

module regex_pipe_ctrl #(
    parameter int CC_ID_BITS = 2
)(
    input  logic                        fetch_valid,
    input  logic [CC_ID_BITS-1:0]       fetch_cc_id,
    input  logic                        exe1_valid,
    input  logic                        exe1_waits,
    input  logic                        exe1_completes,
    input  logic [CC_ID_BITS-1:0]       exe1_cc_id,
    input  logic                        exe2_valid,
    input  logic                        exe2_waits,
    input  logic [CC_ID_BITS-1:0]       exe2_cc_id,

    output logic                        fetch_advance,
    output logic                        exe1_advance,
    output logic                        exe2_load,
    output logic                        exe2_advance,
    output logic                        running,
    output logic [(2**CC_ID_BITS)-1:0]  elaborating_chars
);

    assign exe2_advance = exe2_valid && !exe2_waits;

    // a completing instruction does not need exe2 to be free
    assign exe1_advance = exe1_valid && !exe1_waits &&
                          (exe1_completes || !exe2_valid || exe2_advance);

    assign fetch_advance = fetch_valid && (!exe1_valid || exe1_advance);
    assign exe2_load     = exe1_advance && !exe1_completes;

    assign running = fetch_valid || exe1_valid || exe2_valid;

    always_comb
    begin
        elaborating_chars = '0;
        if (fetch_valid)
        begin
            elaborating_chars[fetch_cc_id] = 1'b1;
        end
        if (exe1_valid)
        begin
            elaborating_chars[exe1_cc_id] = 1'b1;
        end
        if (exe2_valid)
        begin
            elaborating_chars[exe2_cc_id] = 1'b1;
        end
    end

endmodule

//--- verilog/regex_exe1.sv
// first execute stage decoding each instruction and producing its continuation
`timescale 1ns/1ps

module regex_exe1 #(
    parameter int PC_WIDTH   = 9,
    parameter int CC_ID_BITS = 2,
    parameter int CHAR_WIDTH = 8
)(
    input  logic                                   clk,
    input  logic                                   rst,

    input  logic                                   fetch_advance,
    input  logic                                   fetch_valid,
    input  logic [PC_WIDTH-1:0]                    fetch_pc,
    input  logic [CC_ID_BITS-1:0]                  fetch_cc_id,
    input  logic [regex_isa_pkg::INSTR_WIDTH-1:0]  fetch_instr,
    input  logic                                   exe1_advance,

    input  logic [CHAR_WIDTH*(2**CC_ID_BITS)-1:0]  current_characters,
    input  logic [(2**CC_ID_BITS)-1:0]             end_of_string,

    output logic                                   exe1_valid,
    output logic                                   exe1_waits,
    output logic                                   exe1_completes,
    output logic [PC_WIDTH-1:0]                    exe1_pc,
    output logic [CC_ID_BITS-1:0]                  exe1_cc_id,
    output logic [PC_WIDTH-1:0]                    exe1_target,
    output logic                                   accepts,

    output logic                                   exe1_cont_valid,
    output logic [PC_WIDTH-1:0]                    exe1_cont_pc,
    output logic [CC_ID_BITS-1:0]                  exe1_cont_cc_id,
    input  logic                                   exe1_cont_ready
);

    logic [regex_isa_pkg::INSTR_WIDTH-1:0]      exe1_instr;
    regex_isa_pkg::regex_opcode_e               opcode;
    logic [regex_isa_pkg::INSTR_DATA_WIDTH-1:0] data_field;
    logic [CHAR_WIDTH-1:0]                      slot_char;
    logic                                       char_equal;

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            exe1_valid <= 1'b0;
        end
        else if (fetch_advance)
        begin
            exe1_valid <= fetch_valid;
        end
        else if (exe1_advance)
        begin
            exe1_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk)
    begin
        if (fetch_advance)
        begin
            exe1_pc    <= fetch_pc;
            exe1_cc_id <= fetch_cc_id;
            exe1_instr <= fetch_instr;
        end
    end

    assign opcode = regex_isa_pkg::regex_opcode_e'(
        exe1_instr[regex_isa_pkg::INSTR_WIDTH-1 -: regex_isa_pkg::OPCODE_WIDTH]);
    assign data_field  = exe1_instr[regex_isa_pkg::INSTR_DATA_WIDTH-1:0];
    assign exe1_target = data_field[PC_WIDTH-1:0];
    assign slot_char   = current_characters[exe1_cc_id*CHAR_WIDTH +: CHAR_WIDTH];
    assign char_equal  = (slot_char == data_field[CHAR_WIDTH-1:0]);

    always_comb
    begin
        exe1_cont_valid = 1'b0;
        exe1_cont_pc    = exe1_pc + 1'b1;
        exe1_cont_cc_id = exe1_cc_id;
        exe1_completes  = 1'b1;
        accepts         = 1'b0;
        if (exe1_valid)
        begin
            case (opcode)
                regex_isa_pkg::ACCEPT:
                begin
                    accepts = end_of_string[exe1_cc_id];
                end
                regex_isa_pkg::ACCEPT_PARTIAL:
                begin
                    accepts = 1'b1;
                end
                regex_isa_pkg::SPLIT:
                begin
                    // pc+1 leaves here, the target follows from exe2
                    exe1_cont_valid = 1'b1;
                    exe1_completes  = 1'b0;
                end
                regex_isa_pkg::MATCH:
                begin
                    exe1_cont_valid = char_equal;
                    exe1_cont_cc_id = exe1_cc_id + 1'b1;
                end
                regex_isa_pkg::NOT_MATCH:
                begin
                    exe1_cont_valid = !char_equal;
                end
                regex_isa_pkg::MATCH_ANY:
                begin
                    exe1_cont_valid = 1'b1;
                    exe1_cont_cc_id = exe1_cc_id + 1'b1;
                end
                regex_isa_pkg::JMP:
                begin
                    exe1_cont_valid = 1'b1;
                    exe1_cont_pc    = exe1_target;
                end
                default:
                begin
                    // END_NO_ACCEPT drops the thread
                end
            endcase
        end
    end

    assign exe1_waits = exe1_cont_valid && !exe1_cont_ready;

endmodule

//--- verilog/regex_exe2.sv
// second execute stage emitting SPLIT targets and merging both continuation streams
`timescale 1ns/1ps

module regex_exe2 #(
    parameter int PC_WIDTH   = 9,
    parameter int CC_ID_BITS = 2
)(
    input  logic                   clk,
    input  logic                   rst,

    input  logic                   exe2_load,
    input  logic [PC_WIDTH-1:0]    exe1_pc,
    input  logic [CC_ID_BITS-1:0]  exe1_cc_id,
    input  logic [PC_WIDTH-1:0]    exe1_target,
    input  logic                   exe2_advance,

    output logic                   exe2_valid,
    output logic                   exe2_waits,
    output logic [CC_ID_BITS-1:0]  exe2_cc_id,

    input  logic                   exe1_cont_valid,
    input  logic [PC_WIDTH-1:0]    exe1_cont_pc,
    input  logic [CC_ID_BITS-1:0]  exe1_cont_cc_id,
    output logic                   exe1_cont_ready,

    output logic                   output_pc_valid,
    output logic [PC_WIDTH-1:0]    output_pc,
    output logic [CC_ID_BITS-1:0]  output_cc_id,
    input  logic                   output_pc_ready
);

    // the split is kept as its own pc plus the offset to the target
    logic [PC_WIDTH-1:0] exe2_pc;
    logic [PC_WIDTH-1:0] exe2_offset;
    logic [PC_WIDTH-1:0] exe2_target;

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            exe2_valid <= 1'b0;
        end
        else if (exe2_load)
        begin
            exe2_valid <= 1'b1;
        end
        else if (exe2_advance)
        begin
            exe2_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk)
    begin
        if (exe2_load)
        begin
            exe2_pc     <= exe1_pc;
            exe2_offset <= exe1_target - exe1_pc;
            exe2_cc_id  <= exe1_cc_id;
        end
    end

    // modulo sum gives back the absolute target
    assign exe2_target = exe2_pc + exe2_offset;

    // fixed priority, exe2 first, so a stalled exe2 keeps exe1 off the port
    assign exe1_cont_ready = output_pc_ready && !exe2_valid;
    assign exe2_waits      = exe2_valid && !output_pc_ready;

    assign output_pc_valid = exe2_valid || exe1_cont_valid;
    assign output_pc       = exe2_valid ? exe2_target : exe1_cont_pc;
    assign output_cc_id    = exe2_valid ? exe2_cc_id : exe1_cont_cc_id;

endmodule

//--- verilog/regex_cpu_top.sv
// regex engine top level joining fetch, pipeline control and both execute stages
`timescale 1ns/1ps

module regex_cpu_top #(
    parameter int PC_WIDTH       = regex_engine_pkg::DEF_PC_WIDTH,
    parameter int CC_ID_BITS     = regex_engine_pkg::DEF_CC_ID_BITS,
    parameter int CHAR_WIDTH     = regex_engine_pkg::DEF_CHAR_WIDTH,
    parameter int MEM_ADDR_WIDTH = regex_engine_pkg::DEF_MEM_ADDR_WIDTH
)(
    input  logic                                   clk,
    input  logic                                   rst,

    input  logic [CHAR_WIDTH*(2**CC_ID_BITS)-1:0]  current_characters,
    input  logic [(2**CC_ID_BITS)-1:0]             end_of_string,

    input  logic                                   input_pc_valid,
    input  logic [PC_WIDTH-1:0]                    input_pc,
    input  logic [CC_ID_BITS-1:0]                  input_cc_id,
    output logic                                   input_pc_ready,

    output logic                                   memory_valid,
    output logic [MEM_ADDR_WIDTH-1:0]              memory_addr,
    input  logic                                   memory_ready,
    input  logic [regex_isa_pkg::INSTR_WIDTH-1:0]  memory_data,

    output logic                                   output_pc_valid,
    output logic [PC_WIDTH-1:0]                    output_pc,
    output logic [CC_ID_BITS-1:0]                  output_cc_id,
    input  logic                                   output_pc_ready,

    output logic                                   accepts,
    output logic                                   running,
    output logic [(2**CC_ID_BITS)-1:0]             elaborating_chars
);

    // fetch stage state
    logic                                  fetch_valid;
    logic [PC_WIDTH-1:0]                   fetch_pc;
    logic [CC_ID_BITS-1:0]                 fetch_cc_id;
    logic [regex_isa_pkg::INSTR_WIDTH-1:0] fetch_instr;

    // stage movement
    logic                                  fetch_advance;
    logic                                  exe1_advance;
    logic                                  exe2_load;
    logic                                  exe2_advance;

    // exe1 state and continuation
    logic                                  exe1_valid;
    logic                                  exe1_waits;
    logic                                  exe1_completes;
    logic [PC_WIDTH-1:0]                   exe1_pc;
    logic [CC_ID_BITS-1:0]                 exe1_cc_id;
    logic [PC_WIDTH-1:0]                   exe1_target;
    logic                                  exe1_cont_valid;
    logic [PC_WIDTH-1:0]                   exe1_cont_pc;
    logic [CC_ID_BITS-1:0]                 exe1_cont_cc_id;
    logic                                  exe1_cont_ready;

    // exe2 state
    logic                                  exe2_valid;
    logic                                  exe2_waits;
    logic [CC_ID_BITS-1:0]                 exe2_cc_id;

    // port names match the wires above, so implicit connections are used
    regex_fetch #(
        .PC_WIDTH       (PC_WIDTH),
        .CC_ID_BITS     (CC_ID_BITS),
        .MEM_ADDR_WIDTH (MEM_ADDR_WIDTH)
    ) fetch_i (.*);

    regex_pipe_ctrl #(
        .CC_ID_BITS (CC_ID_BITS)
    ) pipe_ctrl_i (.*);

    regex_exe1 #(
        .PC_WIDTH   (PC_WIDTH),
        .CC_ID_BITS (CC_ID_BITS),
        .CHAR_WIDTH (CHAR_WIDTH)
    ) exe1_i (.*);

    regex_exe2 #(
        .PC_WIDTH   (PC_WIDTH),
        .CC_ID_BITS (CC_ID_BITS)
    ) exe2_i (.*);

endmodule

//--- dv/regex_cpu_tb.sv
// regex engine testbench driving tokens from a pattern file against a program memory model
`timescale 1ns/1ps

module regex_cpu_tb;

    localparam int PW = regex_engine_pkg::DEF_PC_WIDTH;
    localparam int CW = regex_engine_pkg::DEF_CC_ID_BITS;
    localparam int AW = regex_engine_pkg::DEF_MEM_ADDR_WIDTH;
    localparam int NS = 2**CW;
    localparam int WW = regex_engine_pkg::DEF_CHAR_WIDTH * NS;
    localparam int IW = regex_isa_pkg::INSTR_WIDTH;
    localparam int MAXV = 32;

    logic clk;
    logic rst;
    logic [WW-1:0] current_characters;
    logic [NS-1:0] end_of_string;
    logic input_pc_valid;
    logic [PW-1:0] input_pc;
    logic [CW-1:0] input_cc_id;
    logic input_pc_ready;
    logic memory_valid;
    logic [AW-1:0] memory_addr;
    logic memory_ready;
    logic [IW-1:0] memory_data;
    logic output_pc_valid;
    logic [PW-1:0] output_pc;
    logic [CW-1:0] output_cc_id;
    logic output_pc_ready;
    logic accepts;
    logic running;
    logic [NS-1:0] elaborating_chars;

    logic [IW-1:0] mem [0:(2**AW)-1];
    logic [PW-1:0] v_pc [0:MAXV-1];
    logic [CW-1:0] v_cc [0:MAXV-1];
    logic [WW-1:0] v_chars [0:MAXV-1];
    logic [NS-1:0] v_eos [0:MAXV-1];
    logic v_acc [0:MAXV-1];
    int v_n [0:MAXV-1];
    logic [PW-1:0] v_opc [0:MAXV-1][0:1];
    logic [CW-1:0] v_occ [0:MAXV-1][0:1];
    int n_vec;

    logic [PW-1:0] out_pc_q [$];
    logic [CW-1:0] out_cc_q [$];
    logic accepts_seen;
    logic stream_mode;
    logic [31:0] rand_state;
    int errors;
    int tests_ok;
    int tests_bad;

    // hold tracking for output stability
    logic hold_pending;
    logic [PW-1:0] hold_pc;
    logic [CW-1:0] hold_cc;

    regex_cpu_top regex_cpu_top_i (.*);

    initial
    begin
        clk = 1'b0;
        forever
        begin
            #20 clk = ~clk;
        end
    end

    function automatic logic [31:0] next_random(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    task automatic check_pc(input string name, input logic [PW-1:0] got,
                            input logic [PW-1:0] exp);
        if (got !== exp)
        begin
            $display("ERR %0t %s got %h expected %h", $time, name, got, exp);
            errors++;
        end
    endtask

    task automatic check_cc_id(input string name, input logic [CW-1:0] got,
                               input logic [CW-1:0] exp);
        if (got !== exp)
        begin
            $display("ERR %0t %s got %0d expected %0d", $time, name, got, exp);
            errors++;
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        if (got !== exp)
        begin
            $display("ERR %0t %s got %b expected %b", $time, name, got, exp);
            errors++;
        end
    endtask

    task automatic check_slots(input string name, input logic [NS-1:0] got,
                               input logic [NS-1:0] exp);
        if (got !== exp)
        begin
            $display("ERR %0t %s got %b expected %b", $time, name, got, exp);
            errors++;
        end
    endtask

    task automatic check_addr(input string name, input logic [AW-1:0] got,
                              input logic [AW-1:0] exp);
        if (got !== exp)
        begin
            $display("ERR %0t %s got %h expected %h", $time, name, got, exp);
            errors++;
        end
    endtask

    task automatic abort_run(input string why);
        $display("timeout: %s at %0t", why, $time);
        $display("*** FAILED ***");
        $finish;
    endtask

    // random stalls on memory and output, memory answers one cycle later
    always @(posedge clk)
    begin
        rand_state = next_random(rand_state);
        memory_ready <= rand_state[28] | rand_state[27];
        output_pc_ready <= stream_mode ? rand_state[20] : 1'b1;
        if (memory_valid && memory_ready)
        begin
            memory_data <= mem[memory_addr];
        end
    end

    // output monitor, sampled away from the driving edge
    always @(negedge clk)
    begin
        if (!rst)
        begin
            if (hold_pending &&
                (!output_pc_valid || output_pc !== hold_pc || output_cc_id !== hold_cc))
            begin
                $display("output token changed while waiting for ready at %0t", $time);
                errors++;
            end
            // request address is the token pc zero-extended
            if (memory_valid)
            begin
                check_addr("memory_addr", memory_addr, AW'(input_pc));
            end
            if (output_pc_valid && output_pc_ready)
            begin
                out_pc_q.push_back(output_pc);
                out_cc_q.push_back(output_cc_id);
            end
            if (accepts)
            begin
                accepts_seen = 1'b1;
            end
            hold_pending = output_pc_valid && !output_pc_ready;
            hold_pc = output_pc;
            hold_cc = output_cc_id;
        end
    end

    task automatic load_patterns();
        int fd;
        string line;
        logic [31:0] t0, t1, t2, t3, t4, t5, t6, t7, t8, t9;
        for (int a = 0; a < 2**AW; a++)
        begin
            mem[a] = {3'd6, 2'b00, a[10:0]};
        end
        n_vec = 0;
        fd = $fopen("dv/regex_patterns.txt", "r");
        if (fd == 0)
        begin
            $display("cannot open dv/regex_patterns.txt");
            $display("*** FAILED ***");
            $finish;
        end
        else
        begin
            while ($fgets(line, fd) != 0)
            begin
                if ($sscanf(line, "M %h %h", t0, t1) == 2)
                begin
                    mem[t0[AW-1:0]] = t1[IW-1:0];
                end
                else if ($sscanf(line, "V %h %h %h %h %h %h %h %h %h %h",
                                 t0, t1, t2, t3, t4, t5, t6, t7, t8, t9) == 10)
                begin
                    v_pc[n_vec] = t0[PW-1:0];
                    v_cc[n_vec] = t1[CW-1:0];
                    v_chars[n_vec] = t2[WW-1:0];
                    v_eos[n_vec] = t3[NS-1:0];
                    v_acc[n_vec] = t4[0];
                    v_n[n_vec] = int'(t5);
                    v_opc[n_vec][0] = t6[PW-1:0];
                    v_occ[n_vec][0] = t7[CW-1:0];
                    v_opc[n_vec][1] = t8[PW-1:0];
                    v_occ[n_vec][1] = t9[CW-1:0];
                    n_vec++;
                end
            end
            $fclose(fd);
        end
    endtask

    // caller sits on a rising edge and returns on the transfer edge
    task automatic send_token(input int i);
        int t;
        input_pc_valid <= 1'b1;
        input_pc <= v_pc[i];
        input_cc_id <= v_cc[i];
        t = 0;
        @(negedge clk);
        while (!input_pc_ready)
        begin
            t++;
            if (t > 200)
            begin
                abort_run("input token never accepted");
            end
            @(negedge clk);
        end
        @(posedge clk);
    endtask

    task automatic wait_idle(input logic [CW-1:0] slot, input logic check_slot);
        int t;
        t = 0;
        @(negedge clk);
        while (running || output_pc_valid)
        begin
            if (check_slot)
            begin
                check_flag("elaborating_chars[slot]", elaborating_chars[slot], 1'b1);
            end
            t++;
            if (t > 2000)
            begin
                abort_run("engine never went idle");
            end
            @(negedge clk);
        end
        check_slots("elaborating_chars", elaborating_chars, '0);
    endtask

    task automatic run_directed(input int i);
        int e0;
        e0 = errors;
        out_pc_q.delete();
        out_cc_q.delete();
        accepts_seen = 1'b0;
        @(posedge clk);
        current_characters <= v_chars[i];
        end_of_string <= v_eos[i];
        send_token(i);
        input_pc_valid <= 1'b0;
        wait_idle(v_cc[i], 1'b1);
        check_flag("accepts", accepts_seen, v_acc[i]);
        if (out_pc_q.size() != v_n[i])
        begin
            $display("token %0d gave %0d outputs instead of %0d", i, out_pc_q.size(), v_n[i]);
            errors++;
        end
        else
        begin
            for (int k = 0; k < v_n[i]; k++)
            begin
                check_pc("output_pc", out_pc_q[k], v_opc[i][k]);
                check_cc_id("output_cc_id", out_cc_q[k], v_occ[i][k]);
            end
        end
        if (errors == e0)
        begin
            tests_ok++;
        end
        else
        begin
            tests_bad++;
        end
        $display("test %0d pc %h slot %0d: %s", i, v_pc[i], v_cc[i],
                 (errors == e0) ? "ok" : "wrong");
    endtask

    task automatic run_stream();
        int e0;
        logic used [0:MAXV-1][0:1];
        logic found;
        e0 = errors;
        out_pc_q.delete();
        out_cc_q.delete();
        for (int i = 0; i < n_vec; i++)
        begin
            used[i][0] = 1'b0;
            used[i][1] = 1'b0;
        end
        stream_mode = 1'b1;
        @(posedge clk);
        current_characters <= v_chars[0];
        end_of_string <= '0;
        for (int i = 0; i < n_vec; i++)
        begin
            send_token(i);
        end
        input_pc_valid <= 1'b0;
        wait_idle('0, 1'b0);
        stream_mode = 1'b0;
        for (int o = 0; o < out_pc_q.size(); o++)
        begin
            found = 1'b0;
            for (int i = 0; i < n_vec && !found; i++)
            begin
                for (int k = 0; k < v_n[i] && !found; k++)
                begin
                    if (!used[i][k] && v_opc[i][k] == out_pc_q[o] && v_occ[i][k] == out_cc_q[o])
                    begin
                        found = 1'b1;
                        used[i][k] = 1'b1;
                        if (k == 1 && !used[i][0])
                        begin
                            $display("split target of token %0d came before pc+1", i);
                            errors++;
                        end
                    end
                end
            end
            if (!found)
            begin
                $display("unexpected output pc %h slot %0d", out_pc_q[o], out_cc_q[o]);
                errors++;
            end
        end
        for (int i = 0; i < n_vec; i++)
        begin
            for (int k = 0; k < v_n[i]; k++)
            begin
                if (!used[i][k])
                begin
                    $display("output %0d of token %0d never appeared", k, i);
                    errors++;
                end
            end
        end
        if (errors == e0)
        begin
            tests_ok++;
        end
        else
        begin
            tests_bad++;
        end
        $display("test stream of %0d tokens: %s", n_vec, (errors == e0) ? "ok" : "wrong");
    endtask

    initial
    begin
        rst = 1'b1;
        current_characters = '0;
        end_of_string = '0;
        input_pc_valid = 1'b0;
        input_pc = '0;
        input_cc_id = '0;
        memory_ready = 1'b0;
        memory_data = '0;
        output_pc_ready = 1'b1;
        rand_state = 32'h4d9647da;
        stream_mode = 1'b0;
        hold_pending = 1'b0;
        hold_pc = '0;
        hold_cc = '0;
        accepts_seen = 1'b0;
        errors = 0;
        tests_ok = 0;
        tests_bad = 0;
        load_patterns();
        repeat (5) @(posedge clk);
        rst <= 1'b0;
        @(negedge clk);
        check_flag("memory_valid", memory_valid, 1'b0);
        check_flag("output_pc_valid", output_pc_valid, 1'b0);
        check_flag("accepts", accepts, 1'b0);
        check_flag("running", running, 1'b0);
        check_slots("elaborating_chars", elaborating_chars, '0);
        $display("test reset state: %s", (errors == 0) ? "ok" : "wrong");
        if (errors == 0)
        begin
            tests_ok++;
        end
        else
        begin
            tests_bad++;
        end
        for (int i = 0; i < n_vec; i++)
        begin
            run_directed(i);
        end
        run_stream();
        $display("tests ok %0d, wrong %0d, errors %0d", tests_ok, tests_bad, errors);
        if (errors == 0 && n_vec > 0)
        begin
            $display("*** PASSED ***");
        end
        else
        begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

//--- filelist.f
verilog/regex_isa_pkg.sv
verilog/regex_engine_pkg.sv
verilog/regex_fetch.sv
verilog/regex_pipe_ctrl.sv
verilog/regex_exe1.sv
verilog/regex_exe2.sv
verilog/regex_cpu_top.sv
dv/regex_cpu_tb.sv

//--- Makefile
# Verilator build for the regex engine testbench

TOP := regex_cpu_tb

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing -f filelist.f --top-module $(TOP)

sim:
	verilator --binary --timing -f filelist.f --top-module $(TOP) -Mdir obj_dir
	./obj_dir/V$(TOP) | tee sim.log
	grep -q -F '*** PASSED ***' sim.log

clean:
	rm -rf obj_dir sim.log

//--- dv/regex_patterns.txt
// M addr instr : program memory word, opcode in bits 15:13
// V pc slot chars eos accepts n_out pc0 cc0 pc1 cc1 : one token and its expected results
M 000 4061
M 001 6062
M 002 8000
M 003 A010
M 004 2020
M 005 C000
M 006 0000
M 007 E000
M 008 21F0
V 000 0 64636261 0 0 1 001 1 000 0
V 000 1 64636261 0 0 0 000 0 000 0
V 001 0 64636261 0 0 1 002 0 000 0
V 001 1 64636261 0 0 0 000 0 000 0
V 002 3 64636261 0 0 1 003 0 000 0
V 003 2 64636261 0 0 1 010 2 000 0
V 004 1 64636261 0 0 2 005 1 020 1
V 005 0 64636261 0 0 0 000 0 000 0
V 006 2 64636261 4 1 0 000 0 000 0
V 006 2 64636261 1 0 0 000 0 000 0
V 007 3 64636261 0 1 0 000 0 000 0
V 008 3 64636261 0 0 2 009 3 1F0 3
